// File: tile_bus_pkg.sv
/* Bus widths, address map, Wishbone request and response structs,
   decode target and arbiter state enums */

package tile_bus_pkg;

  ////////////////////
  // Bus widths

  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int sel_width  = 4;

  // Master 0 is the instruction port, master 1 the data port
  localparam int nr_masters    = 2;
  localparam int mst_idx_width = (nr_masters > 1) ? $clog2(nr_masters) : 1;

  ////////////////////
  // Address map

  localparam int region_msb = 31;
  localparam int region_lsb = 28;

  localparam logic [region_msb-region_lsb:0] region_mem = 4'h0;
  localparam logic [region_msb-region_lsb:0] region_rom = 4'hf;

  // Data memory, 1 KiB, word index from address bits 9:2
  localparam int mem_words     = 256;
  localparam int mem_idx_width = $clog2(mem_words);

  // Boot ROM, word index from address bits 5:2
  localparam int rom_words     = 16;
  localparam int rom_idx_width = $clog2(rom_words);

  ////////////////////
  // Bus types

  // Classic single cycle request, 71 bits
  typedef struct packed {
    logic [addr_width-1:0] adr;
    logic [data_width-1:0] dat;
    logic [sel_width-1:0]  sel;
    logic                  we;
    logic                  cyc;
    logic                  stb;
  } wb_req_t;

  // Slave response, 34 bits
  typedef struct packed {
    logic [data_width-1:0] dat;
    logic                  ack;
    logic                  err;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    sel_mem,
    sel_rom,
    sel_none
  } slave_sel_e;

  typedef enum logic {
    arb_idle,
    arb_owned
  } arb_state_e;

endpackage

// File: tile_bus_arbiter.sv
/* Round-robin bus arbiter, one grant per Wishbone cycle */

`timescale 1ns/1ps

module tile_bus_arbiter
  import tile_bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic [nr_masters-1:0] cyc_i,
  output logic [nr_masters-1:0] grant_o,
  output logic                  owned_o
);

  arb_state_e               state_q;
  logic [mst_idx_width-1:0] last_q;
  logic [mst_idx_width-1:0] next_idx;
  logic                     next_valid;

  ////////////////////
  // Next master

  // Scan from the lowest priority up, so the master right after
  // the last one served overwrites everyone else
  always_comb begin
    int cand;
    next_idx   = last_q;
    next_valid = 1'b0;
    for (int off = nr_masters; off >= 1; off--) begin
      cand = (int'(last_q) + off) % nr_masters;
      if (cyc_i[cand]) begin
        next_idx   = mst_idx_width'(cand);
        next_valid = 1'b1;
      end
    end
  end

  ////////////////////
  // Grant state

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= arb_idle;
      grant_o <= '0;
      // Master 0 wins the first contest after reset
      last_q  <= mst_idx_width'(nr_masters - 1);
    end else begin
      case (state_q)
        arb_idle: begin
          if (next_valid) begin
            state_q <= arb_owned;
            grant_o <= nr_masters'(1) << next_idx;
            last_q  <= next_idx;
          end
        end
        arb_owned: begin
          // Owner has ended its cycle
          if (!(|(cyc_i & grant_o))) begin
            state_q <= arb_idle;
            grant_o <= '0;
          end
        end
        default: begin
          state_q <= arb_idle;
          grant_o <= '0;
        end
      endcase
    end
  end

  assign owned_o = (state_q == arb_owned);

endmodule

// File: tile_bus_decoder.sv
/* Region decoder for the tile bus with error responder for unmapped
   addresses */

`timescale 1ns/1ps

module tile_bus_decoder
  import tile_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst_i,
  input  wb_req_t    req_i,
  output slave_sel_e target_o,
  output logic       err_o
);

  logic [region_msb-region_lsb:0] region;
  logic                           err_q;

  assign region = req_i.adr[region_msb:region_lsb];

  ////////////////////
  // Range compare

  always_comb begin
    case (region)
      region_mem: target_o = sel_mem;
      region_rom: target_o = sel_rom;
      // 4'he used to be the adapter, unmapped here
      default:    target_o = sel_none;
    endcase
  end

  ////////////////////
  // Error responder

  // One err pulse per strobed transfer, the master drops stb after it
  always_ff @(posedge clk) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req_i.cyc & req_i.stb & (target_o == sel_none) & ~err_q;
    end
  end

  assign err_o = err_q;

endmodule

// File: tile_bus.sv
/* Shared tile bus: request mux for the granted master, slave strobe
   select and response routing */

`timescale 1ns/1ps

module tile_bus
  import tile_bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst_i,
  input  wb_req_t m_req_i [nr_masters],
  output wb_rsp_t m_rsp_o [nr_masters],
  output wb_req_t mem_req_o,
  input  wb_rsp_t mem_rsp_i,
  output wb_req_t rom_req_o,
  input  wb_rsp_t rom_rsp_i
);

  logic [nr_masters-1:0] m_cyc;
  logic [nr_masters-1:0] grant;
  logic                  owned;
  wb_req_t               bus_req;
  wb_rsp_t               bus_rsp;
  slave_sel_e            target;
  logic                  dec_err;

  for (genvar m = 0; m < nr_masters; m++) begin : gen_cyc
    assign m_cyc[m] = m_req_i[m].cyc;
  end

  tile_bus_arbiter u_arbiter (
    .clk     (clk),
    .rst_i   (rst_i),
    .cyc_i   (m_cyc),
    .grant_o (grant),
    .owned_o (owned)
  );

  ////////////////////
  // Request path

  // Grant is one-hot, nothing drives the bus while idle
  always_comb begin
    bus_req = '0;
    for (int m = 0; m < nr_masters; m++) begin
      if (grant[m]) begin
        bus_req = m_req_i[m];
      end
    end
    bus_req.cyc = bus_req.cyc & owned;
    bus_req.stb = bus_req.stb & owned;
  end

  tile_bus_decoder u_decoder (
    .clk      (clk),
    .rst_i    (rst_i),
    .req_i    (bus_req),
    .target_o (target),
    .err_o    (dec_err)
  );

  always_comb begin
    mem_req_o     = bus_req;
    mem_req_o.stb = bus_req.stb & (target == sel_mem);
    rom_req_o     = bus_req;
    rom_req_o.stb = bus_req.stb & (target == sel_rom);
  end

  ////////////////////
  // Response path

  always_comb begin
    case (target)
      sel_mem: bus_rsp = mem_rsp_i;
      sel_rom: bus_rsp = rom_rsp_i;
      default: begin
        bus_rsp     = '0;
        bus_rsp.err = dec_err;
      end
    endcase
  end

  // Only the owner hears back
  for (genvar m = 0; m < nr_masters; m++) begin : gen_rsp
    assign m_rsp_o[m] = grant[m] ? bus_rsp : '0;
  end

endmodule

// File: tile_sram.sv
/* Single-port tile data memory, Wishbone slave with byte selects */

`timescale 1ns/1ps

module tile_sram
  import tile_bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  logic [data_width-1:0]    mem [mem_words];
  logic [mem_idx_width-1:0] idx;
  logic [data_width-1:0]    rdat_q;
  logic                     ack_q;
  logic                     access;

  // Upper address bits in the region alias onto the same words
  assign idx    = req_i.adr[mem_idx_width+1:2];
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  initial begin
    for (int w = 0; w < mem_words; w++) begin
      mem[w] = '0;
    end
  end

  ////////////////////
  // Array access

  always_ff @(posedge clk) begin
    if (access && req_i.we) begin
      for (int b = 0; b < sel_width; b++) begin
        if (req_i.sel[b]) begin
          mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
        end
      end
    end
    // Lands in the ack cycle
    rdat_q <= mem[idx];
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign rsp_o = '{dat: rdat_q, ack: ack_q, err: 1'b0};

endmodule

// File: tile_bootrom.sv
/* Boot ROM slave with a fixed 16 word program */

`timescale 1ns/1ps

module tile_bootrom
  import tile_bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  logic [rom_idx_width-1:0] idx;
  logic [data_width-1:0]    rom_word;
  logic [data_width-1:0]    rdat_q;
  logic                     ack_q;

  assign idx = req_i.adr[rom_idx_width+1:2];

  ////////////////////
  // Boot program

  // Set up r1 and r2, store and load back a test word, then jump to RAM
  always_comb begin
    case (idx)
      4'd0:    rom_word = 32'h1800_0000;
      4'd1:    rom_word = 32'ha820_0000;
      4'd2:    rom_word = 32'h1840_0000;
      4'd3:    rom_word = 32'ha842_0100;
      4'd4:    rom_word = 32'h9c60_0004;
      4'd5:    rom_word = 32'hd402_1800;
      4'd6:    rom_word = 32'h8482_0000;
      4'd7:    rom_word = 32'he403_2000;
      4'd8:    rom_word = 32'h1000_0003;
      4'd9:    rom_word = 32'h1500_0000;
      4'd10:   rom_word = 32'h1500_0001;
      4'd11:   rom_word = 32'h0000_0000;
      4'd12:   rom_word = 32'h1500_0000;
      4'd13:   rom_word = 32'h4400_1000;
      default: rom_word = 32'h1500_0000;
    endcase
  end

  // Writes get an ack and change nothing
  always_ff @(posedge clk) begin
    rdat_q <= rom_word;
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i.cyc & req_i.stb & ~ack_q;
    end
  end

  assign rsp_o = '{dat: rdat_q, ack: ack_q, err: 1'b0};

endmodule

// File: tile_mem_system.sv
/* Tile memory system: shared bus with data memory and boot ROM */

`timescale 1ns/1ps

module tile_mem_system
  import tile_bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst_i,
  input  wb_req_t m_req_i [nr_masters],
  output wb_rsp_t m_rsp_o [nr_masters]
);

  wb_req_t mem_req;
  wb_rsp_t mem_rsp;
  wb_req_t rom_req;
  wb_rsp_t rom_rsp;

  tile_bus u_bus (
    .clk       (clk),
    .rst_i     (rst_i),
    .m_req_i   (m_req_i),
    .m_rsp_o   (m_rsp_o),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp),
    .rom_req_o (rom_req),
    .rom_rsp_i (rom_rsp)
  );

  // Region 4'h0
  tile_sram u_sram (
    .clk   (clk),
    .rst_i (rst_i),
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

  // Region 4'hf
  tile_bootrom u_bootrom (
    .clk   (clk),
    .rst_i (rst_i),
    .req_i (rom_req),
    .rsp_o (rom_rsp)
  );

endmodule

// File: tb_tile_checks.svh
/* Typed response, latency and grant order checks, plus the driver
   for one Wishbone classic transfer */

`ifndef TB_TILE_CHECKS_SVH
`define TB_TILE_CHECKS_SVH

  // Data only where a read returns it
  task automatic check_rsp(input int m, input wb_rsp_t exp_rsp, input wb_rsp_t got,
                           input bit chk_dat);
    if (got.err !== exp_rsp.err) begin
      abort_run($sformatf("FAIL m_rsp_o[%0d].err expected %h actual %h",
                          m, exp_rsp.err, got.err));
    end else if (got.ack !== exp_rsp.ack) begin
      abort_run($sformatf("FAIL m_rsp_o[%0d].ack expected %h actual %h",
                          m, exp_rsp.ack, got.ack));
    end else if (chk_dat && (got.dat !== exp_rsp.dat)) begin
      abort_run($sformatf("FAIL m_rsp_o[%0d].dat expected %h actual %h",
                          m, exp_rsp.dat, got.dat));
    end
  endtask

  task automatic check_latency(input int m, input int exp_cycles, input int got_cycles);
    if (got_cycles != exp_cycles) begin
      abort_run($sformatf("FAIL m_rsp_o[%0d] latency expected %h actual %h",
                          m, exp_cycles, got_cycles));
    end
  endtask

  // Completions alternate, starting after the last master served
  task automatic check_grant_order(input logic [mst_idx_width-1:0] first,
                                   input logic [mst_idx_width-1:0] order [$]);
    logic [mst_idx_width-1:0] exp_mst;
    for (int pos = 0; pos < order.size(); pos++) begin
      exp_mst = mst_idx_width'((int'(first) + pos) % nr_masters);
      if (order[pos] !== exp_mst) begin
        abort_run($sformatf("FAIL grant_order[%0d] expected %h actual %h",
                            pos, exp_mst, order[pos]));
      end
    end
  endtask

  ////////////////////
  // Single transfer

  task automatic run_transfer(input int m, input int i, input bit solo);
    wb_rsp_t rsp;
    int      edges;
    bit      rd;
    rsp   = '0;
    edges = 0;
    rd    = !pat_req[i].we && !pat_exp[i].err;
    @(posedge clk);
    m_req[m] <= pat_req[i];
    // Request held until ack or err
    while (!(rsp.ack || rsp.err)) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      rsp = m_rsp[m];
    end
    check_rsp(m, pat_exp[i], rsp, rd);
    if (solo) begin
      check_latency(m, 2, edges);
    end
    done_q.push_back(mst_idx_width'(m));
    // Cycle ends in the clock after the response
    @(posedge clk);
    m_req[m] <= '0;
  endtask

`endif

// File: tb_tile_mem_system.sv
/* Testbench for the tile memory system with clock, reset, pattern
   reader, two master drivers and a watchdog */

`timescale 1ns/1ps

module tb_tile_mem_system
  import tile_bus_pkg::*;
();

  localparam int max_lines    = 64;
  localparam int reset_cycles = 5;

  logic    clk;
  logic    rst_i;
  wb_req_t m_req [nr_masters];
  wb_rsp_t m_rsp [nr_masters];

  // Pattern table
  int      nr_lines = 0;
  int      pat_mst [max_lines];
  int      pat_grp [max_lines];
  wb_req_t pat_req [max_lines];
  wb_rsp_t pat_exp [max_lines];

  // Completion order inside one group
  logic [mst_idx_width-1:0] done_q [$];
  logic [mst_idx_width-1:0] last_served;

  tile_mem_system i_tile_mem_system (
    .clk     (clk),
    .rst_i   (rst_i),
    .m_req_i (m_req),
    .m_rsp_o (m_rsp)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  `include "tb_tile_checks.svh"

  ////////////////////
  // Pattern reader

  task automatic load_patterns();
    int          fd;
    int          cnt;
    int          n;
    string       line;
    int          t_mst;
    int          t_we;
    int          t_err;
    int          t_grp;
    logic [31:0] t_adr;
    logic [31:0] t_wdat;
    logic [31:0] t_exp;
    logic [3:0]  t_sel;
    n  = 0;
    fd = $fopen("tile_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open tile_patterns.txt for reading");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if ((line.len() > 0) && (line[0] != "#")) begin
        cnt = $sscanf(line, "%d %d %h %h %h %h %d %d",
                      t_mst, t_we, t_adr, t_wdat, t_sel, t_exp, t_err, t_grp);
        if (cnt == 8) begin
          if ((t_mst < 0) || (t_mst >= nr_masters) || (n >= max_lines)) begin
            abort_run("Bad master number or too many lines in tile_patterns.txt");
          end
          pat_mst[n] = t_mst;
          pat_grp[n] = t_grp;
          pat_req[n] = '{adr: t_adr, dat: t_wdat, sel: t_sel, we: t_we[0],
                         cyc: 1'b1, stb: 1'b1};
          pat_exp[n] = '{dat: t_exp, ack: ~t_err[0], err: t_err[0]};
          n++;
        end
      end
    end
    $fclose(fd);
    if (n == 0) begin
      abort_run("No transfers found in tile_patterns.txt");
    end
    nr_lines = n;
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Each line gets 20 cycles of budget
  initial begin
    wait (nr_lines > 0);
    repeat (nr_lines * 20 + reset_cycles) @(posedge clk);
    abort_run("Bus hung, the transfers did not finish before the watchdog ran out");
  end

  ////////////////////
  // Main sequence

  initial begin
    int          idx [nr_masters];
    int          first_i;
    int          next_i;
    int          n_grp;
    bit          solo;
    int unsigned gap;
    rst_i <= 1'b1;
    m_req <= '{default: '0};
    // Master 0 wins the first contest
    last_served = mst_idx_width'(nr_masters - 1);
    void'($urandom(32'h7f4f));
    load_patterns();
    repeat (reset_cycles) @(posedge clk);
    rst_i <= 1'b0;

    first_i = 0;
    while (first_i < nr_lines) begin
      idx    = '{default: -1};
      n_grp  = 0;
      next_i = first_i;
      while ((next_i < nr_lines) && (pat_grp[next_i] == pat_grp[first_i])) begin
        if (idx[pat_mst[next_i]] != -1) begin
          abort_run("Two lines for one master share a group in tile_patterns.txt");
        end
        idx[pat_mst[next_i]] = next_i;
        n_grp++;
        next_i++;
      end
      solo = (n_grp == 1);
      gap  = $urandom % 4;
      repeat (gap) @(posedge clk);

      // Both masters of a group raise cyc in the same clock
      fork
        if (idx[0] >= 0) run_transfer(0, idx[0], solo);
        if (idx[1] >= 0) run_transfer(1, idx[1], solo);
      join

      if (!solo) begin
        check_grant_order(mst_idx_width'((int'(last_served) + 1) % nr_masters), done_q);
      end
      last_served = done_q[$];
      done_q.delete();
      first_i = next_i;
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: tile_mem_system.f
+incdir+.
tile_bus_pkg.sv
tile_bus_arbiter.sv
tile_bus_decoder.sv
tile_bus.sv
tile_sram.sv
tile_bootrom.sv
tile_mem_system.sv
tb_tile_mem_system.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_tile_mem_system
FILELIST  := tile_mem_system.f
OBJDIR    := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: tile_patterns.txt
# master we adr wdat sel exp_dat exp_err group
# Lines with the same group tag start together on both masters
# Read data is checked only on reads without err
0 1 00000010 11223344 f 00000000 0 0
1 0 00000010 00000000 f 11223344 0 1
1 1 00000020 a5a5a5a5 f 00000000 0 2
0 0 00000020 00000000 f a5a5a5a5 0 3
1 1 00000010 ffeeddcc 5 00000000 0 4
0 0 00000010 00000000 f 11ee33cc 0 5
0 1 00000024 0badf00d c 00000000 0 6
1 0 00000024 00000000 f 0bad0000 0 7
1 0 0abc0410 00000000 f 11ee33cc 0 8
0 0 f0000000 00000000 f 18000000 0 9
1 0 f000000c 00000000 f a8420100 0 10
0 0 f0000034 00000000 f 44001000 0 11
1 1 f0000010 deadbeef f 00000000 0 12
0 0 f0000010 00000000 f 9c600004 0 13
0 0 e0000000 00000000 f 00000000 1 14
1 1 10000000 12345678 f 00000000 1 15
1 0 70000040 00000000 f 00000000 1 16
0 1 00000100 cafe0001 f 00000000 0 17
1 1 00000104 cafe0002 f 00000000 0 17
0 0 00000104 00000000 f cafe0002 0 18
1 0 00000100 00000000 f cafe0001 0 18
0 0 f0000004 00000000 f a8200000 0 19
0 0 00000010 00000000 f 11ee33cc 0 20
1 0 e0000010 00000000 f 00000000 1 20
